// ==== design/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	// Machine word and register file geometry
	localparam int dataWidth = 16;
	localparam int regCount = 16;
	localparam int regIdxWidth = $clog2(regCount);
	localparam int opcodeWidth = 4;
	localparam int immWidth = 8;

	// Instruction field positions
	localparam int opcodeMsb = dataWidth - 1;
	localparam int opcodeLsb = dataWidth - opcodeWidth;
	localparam int dstMsb = opcodeLsb - 1;
	localparam int dstLsb = dstMsb - regIdxWidth + 1;
	localparam int srcMsb = dstLsb - 1;
	localparam int srcLsb = srcMsb - regIdxWidth + 1;
	localparam int immMsb = immWidth - 1;
	localparam int immLsb = 0;

	typedef enum logic [opcodeWidth-1:0] {
		ADD  = 4'h0,
		SUB  = 4'h1,
		AND  = 4'h2,
		OR   = 4'h3,
		XOR  = 4'h4,
		SHL  = 4'h5,
		SHR  = 4'h6,
		MOV  = 4'h7,
		LDI  = 4'h8,
		LD   = 4'h9,
		ST   = 4'hA,
		JMP  = 4'hB,
		JR   = 4'hC,
		JZ   = 4'hD,
		JC   = 4'hE,
		HALT = 4'hF
	} opcodeT;

	typedef enum logic [1:0] {
		FETCH,
		EXEC,
		MEMWR,
		HALTED
	} seqStateT;

	typedef enum logic [1:0] {
		INCR,
		IMMED,
		REGSRC
	} nextPcSelT;

	// Opcodes that produce an ALU result and update the flags
	function automatic logic isAluOp(opcodeT op);
		return op inside {ADD, SUB, AND, OR, XOR, SHL, SHR, MOV};
	endfunction

endpackage

`default_nettype wire

// ==== design/cpuCtrlIf.sv ====
`timescale 1ns/100ps
`default_nettype none

interface cpuCtrlIf;

	cpuPkg::opcodeT opcode;
	logic [cpuPkg::regIdxWidth-1:0] regDst;
	logic [cpuPkg::regIdxWidth-1:0] regSrc;
	logic regWe;
	logic memWe;
	logic immMode;
	logic indMode;
	cpuPkg::nextPcSelT nextPcSel;
	// Zero-extended immediate
	logic [cpuPkg::dataWidth-1:0] instrData;
	logic isHalt;

	modport decoder (
		output opcode, regDst, regSrc, regWe, memWe, immMode, indMode,
		output nextPcSel, instrData, isHalt
	);

	modport datapath (
		input opcode, regDst, regSrc, regWe, immMode, indMode, instrData
	);

	modport pc (
		input nextPcSel, instrData
	);

	modport seq (
		input memWe, isHalt
	);

endinterface

`default_nettype wire

// ==== design/instrDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instrDecoder (
	input logic clk,
	input logic rst,
	input logic [cpuPkg::dataWidth-1:0] instrData,
	input logic fetchStep,
	input logic cFlag,
	input logic zFlag,
	cpuCtrlIf.decoder ctrl
);

	logic [cpuPkg::dataWidth-1:0] instrReg;
	cpuPkg::opcodeT op;

	// Instruction register, loaded once per instruction in FETCH
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			instrReg <= '0;
		end else if (fetchStep) begin
			instrReg <= instrData;
		end
	end

	assign op = cpuPkg::opcodeT'(instrReg[cpuPkg::opcodeMsb:cpuPkg::opcodeLsb]);

	always_comb begin
		ctrl.opcode = op;
		ctrl.regDst = instrReg[cpuPkg::dstMsb:cpuPkg::dstLsb];
		ctrl.regSrc = instrReg[cpuPkg::srcMsb:cpuPkg::srcLsb];
		ctrl.instrData = {
			{(cpuPkg::dataWidth - cpuPkg::immWidth){1'b0}},
			instrReg[cpuPkg::immMsb:cpuPkg::immLsb]
		};

		// Write-back only for results that land in a register
		ctrl.regWe = cpuPkg::isAluOp(op) || (op == cpuPkg::LDI) || (op == cpuPkg::LD);
		ctrl.memWe = (op == cpuPkg::ST);
		ctrl.immMode = (op == cpuPkg::LDI);
		ctrl.indMode = (op == cpuPkg::LD);
		ctrl.isHalt = (op == cpuPkg::HALT);
	end

	// Next PC source, untaken branches fall through to INCR
	always_comb begin
		case (op)
			cpuPkg::JMP: begin
				ctrl.nextPcSel = cpuPkg::IMMED;
			end
			cpuPkg::JR: begin
				ctrl.nextPcSel = cpuPkg::REGSRC;
			end
			cpuPkg::JZ: begin
				ctrl.nextPcSel = zFlag ? cpuPkg::IMMED : cpuPkg::INCR;
			end
			cpuPkg::JC: begin
				ctrl.nextPcSel = cFlag ? cpuPkg::IMMED : cpuPkg::INCR;
			end
			default: begin
				ctrl.nextPcSel = cpuPkg::INCR;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/registerFile.sv ====
`timescale 1ns/100ps
`default_nettype none

module registerFile (
	input logic clk,
	input logic rst,
	cpuCtrlIf.datapath ctrl,
	input logic execStep,
	input logic [cpuPkg::dataWidth-1:0] aluOut,
	input logic [cpuPkg::dataWidth-1:0] memReadData,
	output logic [cpuPkg::dataWidth-1:0] dstData,
	output logic [cpuPkg::dataWidth-1:0] srcData
);

	logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];
	logic [cpuPkg::dataWidth-1:0] writeData;

	// Write-back source: immediate, memory, or ALU
	always_comb begin
		if (ctrl.immMode) begin
			writeData = ctrl.instrData;
		end else if (ctrl.indMode) begin
			writeData = memReadData;
		end else begin
			writeData = aluOut;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < cpuPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (execStep && ctrl.regWe) begin
			regs[ctrl.regDst] <= writeData;
		end
	end

	assign dstData = regs[ctrl.regDst];
	assign srcData = regs[ctrl.regSrc];

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
	input logic clk,
	input logic rst,
	cpuCtrlIf.datapath ctrl,
	input logic execStep,
	input logic [cpuPkg::dataWidth-1:0] dstData,
	input logic [cpuPkg::dataWidth-1:0] srcData,
	output logic [cpuPkg::dataWidth-1:0] aluOut,
	output logic cFlag,
	output logic zFlag
);

	// Top bit carries the carry or borrow out
	logic [cpuPkg::dataWidth:0] wideResult;

	always_comb begin
		case (ctrl.opcode)
			cpuPkg::ADD: begin
				wideResult = {1'b0, dstData} + {1'b0, srcData};
			end
			// Bit 16 ends up set exactly when dst < src
			cpuPkg::SUB: begin
				wideResult = {1'b0, dstData} - {1'b0, srcData};
			end
			cpuPkg::AND: begin
				wideResult = {1'b0, dstData & srcData};
			end
			cpuPkg::OR: begin
				wideResult = {1'b0, dstData | srcData};
			end
			cpuPkg::XOR: begin
				wideResult = {1'b0, dstData ^ srcData};
			end
			cpuPkg::SHL: begin
				wideResult = {dstData[cpuPkg::dataWidth-1], dstData[cpuPkg::dataWidth-2:0], 1'b0};
			end
			cpuPkg::SHR: begin
				wideResult = {dstData[0], 1'b0, dstData[cpuPkg::dataWidth-1:1]};
			end
			cpuPkg::MOV: begin
				wideResult = {1'b0, srcData};
			end
			default: begin
				wideResult = {1'b0, dstData};
			end
		endcase
	end

	assign aluOut = wideResult[cpuPkg::dataWidth-1:0];

	// Flags hold until the next executed ALU instruction
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (execStep && cpuPkg::isAluOp(ctrl.opcode)) begin
			cFlag <= wideResult[cpuPkg::dataWidth];
			zFlag <= (aluOut == '0);
		end
	end

endmodule

`default_nettype wire

// ==== design/programCounter.sv ====
`timescale 1ns/100ps
`default_nettype none

module programCounter (
	input logic clk,
	input logic rst,
	cpuCtrlIf.pc ctrl,
	input logic pcStep,
	input logic [cpuPkg::dataWidth-1:0] srcData,
	output logic [cpuPkg::dataWidth-1:0] instrAddr
);

	logic [cpuPkg::dataWidth-1:0] nextPc;

	always_comb begin
		case (ctrl.nextPcSel)
			cpuPkg::IMMED: begin
				nextPc = ctrl.instrData;
			end
			cpuPkg::REGSRC: begin
				nextPc = srcData;
			end
			default: begin
				nextPc = instrAddr + 1'b1;
			end
		endcase
	end

	// Only moves at the last cycle of an instruction
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			instrAddr <= '0;
		end else if (pcStep) begin
			instrAddr <= nextPc;
		end
	end

endmodule

`default_nettype wire

// ==== design/controlSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module controlSequencer (
	input logic clk,
	input logic rst,
	cpuCtrlIf.seq ctrl,
	output logic fetchStep,
	output logic execStep,
	output logic pcStep,
	output logic memWe,
	output logic halted
);

	cpuPkg::seqStateT state;
	cpuPkg::seqStateT nextState;

	always_comb begin
		case (state)
			cpuPkg::FETCH: begin
				nextState = cpuPkg::EXEC;
			end
			cpuPkg::EXEC: begin
				if (ctrl.memWe) begin
					nextState = cpuPkg::MEMWR;
				end else if (ctrl.isHalt) begin
					nextState = cpuPkg::HALTED;
				end else begin
					nextState = cpuPkg::FETCH;
				end
			end
			cpuPkg::MEMWR: begin
				nextState = cpuPkg::FETCH;
			end
			// Only reset leaves HALTED
			default: begin
				nextState = cpuPkg::HALTED;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= cpuPkg::FETCH;
		end else begin
			state <= nextState;
		end
	end

	assign fetchStep = (state == cpuPkg::FETCH);
	assign execStep = (state == cpuPkg::EXEC);
	// Stores advance the PC after MEMWR, everything else after EXEC
	assign pcStep = ((state == cpuPkg::EXEC) && !ctrl.memWe) || (state == cpuPkg::MEMWR);
	assign memWe = (state == cpuPkg::MEMWR);
	assign halted = (state == cpuPkg::HALTED);

endmodule

`default_nettype wire

// ==== design/cpuCore.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuCore (
	input logic clk,
	input logic rst,
	output logic [cpuPkg::dataWidth-1:0] instrAddr,
	input logic [cpuPkg::dataWidth-1:0] instrData,
	output logic [cpuPkg::dataWidth-1:0] memAddr,
	output logic [cpuPkg::dataWidth-1:0] memWriteData,
	input logic [cpuPkg::dataWidth-1:0] memReadData,
	output logic memWe,
	output logic halted
);

	logic fetchStep;
	logic execStep;
	logic pcStep;
	logic cFlag;
	logic zFlag;
	logic [cpuPkg::dataWidth-1:0] dstData;
	logic [cpuPkg::dataWidth-1:0] srcData;
	logic [cpuPkg::dataWidth-1:0] aluOut;

	cpuCtrlIf ctrl ();

	instrDecoder iDecoder (
		.clk(clk),
		.rst(rst),
		.instrData(instrData),
		.fetchStep(fetchStep),
		.cFlag(cFlag),
		.zFlag(zFlag),
		.ctrl(ctrl.decoder)
	);

	registerFile iRegFile (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl.datapath),
		.execStep(execStep),
		.aluOut(aluOut),
		.memReadData(memReadData),
		.dstData(dstData),
		.srcData(srcData)
	);

	alu iAlu (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl.datapath),
		.execStep(execStep),
		.dstData(dstData),
		.srcData(srcData),
		.aluOut(aluOut),
		.cFlag(cFlag),
		.zFlag(zFlag)
	);

	programCounter iPc (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl.pc),
		.pcStep(pcStep),
		.srcData(srcData),
		.instrAddr(instrAddr)
	);

	controlSequencer iSeq (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl.seq),
		.fetchStep(fetchStep),
		.execStep(execStep),
		.pcStep(pcStep),
		.memWe(memWe),
		.halted(halted)
	);

	// ST addresses through dst, LD through src
	assign memAddr = ctrl.memWe ? dstData : srcData;
	assign memWriteData = srcData;

endmodule

`default_nettype wire

// ==== test/cpuCore_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuCoreAssertions (
	input logic clk,
	input logic rst,
	input logic [cpuPkg::dataWidth-1:0] instrAddr,
	input logic memWe,
	input logic halted
);

	// A store owns exactly one write cycle
	noBackToBackWrite: assert property (
		@(posedge clk) disable iff (rst) memWe |=> !memWe
	) else $error("memWe high in two consecutive cycles");

	pcFrozenWhenHalted: assert property (
		@(posedge clk) disable iff (rst) halted |=> $stable(instrAddr)
	) else $error("instrAddr moved while halted");

	quietAfterReset: assert property (
		@(posedge clk) $fell(rst) |-> !memWe
	) else $error("memWe high in the first cycle after reset");

endmodule

bind cpuCore cpuCoreAssertions iAssertions (
	.clk(clk),
	.rst(rst),
	.instrAddr(instrAddr),
	.memWe(memWe),
	.halted(halted)
);

`default_nettype wire

// ==== test/cpuCoreTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuCoreTb;

	localparam int resetCycles = 16;
	localparam int maxInstr = 200;
	// Tests 1 to 4, five random batches and the reset pulses of the halt test
	localparam int programRuns = 12;
	localparam int cycleLimit = programRuns * (maxInstr * 3 + resetCycles + 2) + 500;

	logic clk;
	logic rst;
	logic [cpuPkg::dataWidth-1:0] instrAddr;
	logic [cpuPkg::dataWidth-1:0] instrData;
	logic [cpuPkg::dataWidth-1:0] memAddr;
	logic [cpuPkg::dataWidth-1:0] memWriteData;
	logic [cpuPkg::dataWidth-1:0] memReadData;
	logic memWe;
	logic halted;

	logic [15:0] imem [256];
	logic [15:0] dmem [256];
	logic [15:0] dmemInit [256];
	int loadPtr;
	int cycleCount = 0;
	logic [31:0] lfsrState = 32'h11c6;

	cpuCore i_dut (.*);

	assign instrData = imem[instrAddr[7:0]];
	assign memReadData = dmem[memAddr[7:0]];

	// Data image reloads while reset is held
	always @(posedge clk) begin
		if (rst) begin
			dmem <= dmemInit;
		end else if (memWe) begin
			dmem[memAddr[7:0]] <= memWriteData;
		end
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout waiting for halt");
			$display("tests failed");
			$fatal(1);
		end
	end

	// Taps 32, 22, 2 and 1
	function automatic logic lfsrStep();
		logic fb;
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] randWord();
		logic [15:0] w;
		for (int i = 0; i < 16; i++) begin
			w = {w[14:0], lfsrStep()};
		end
		return w;
	endfunction

	function automatic logic [15:0] fillWord(int a);
		return {a[7:0] ^ 8'h5a, a[7:0]};
	endfunction

	task automatic checkWord(string testName, logic [15:0] expected, logic [15:0] actual);
		assert (actual === expected) else begin
			$display("mismatch %s expected %h actual %h", testName, expected, actual);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic fillMemories();
		for (int a = 0; a < 256; a++) begin
			// Unused slots halt and carry their own address
			imem[a] = {cpuPkg::HALT, 4'h0, a[7:0]};
			dmemInit[a] = fillWord(a);
		end
		loadPtr = 0;
	endtask

	task automatic emitRegOp(cpuPkg::opcodeT op, int dst, int src);
		imem[loadPtr] = {op, dst[3:0], src[3:0], 4'h0};
		loadPtr++;
	endtask

	task automatic emitImmOp(cpuPkg::opcodeT op, int dst, int imm);
		imem[loadPtr] = {op, dst[3:0], imm[7:0]};
		loadPtr++;
	endtask

	// r15 is the address scratch register
	task automatic storeTo(int addr, int src);
		emitImmOp(cpuPkg::LDI, 15, addr);
		emitRegOp(cpuPkg::ST, 15, src);
	endtask

	// Stores 1 when carry is set, 0 otherwise
	task automatic storeCarryFlag(int addr);
		emitImmOp(cpuPkg::LDI, 14, 1);
		emitImmOp(cpuPkg::JC, 0, loadPtr + 2);
		emitImmOp(cpuPkg::LDI, 14, 0);
		storeTo(addr, 14);
	endtask

	task automatic buildWord(int dst, logic [15:0] value);
		emitImmOp(cpuPkg::LDI, dst, value[15:8]);
		repeat (8) emitRegOp(cpuPkg::SHL, dst, 0);
		emitImmOp(cpuPkg::LDI, 12, value[7:0]);
		emitRegOp(cpuPkg::OR, dst, 12);
	endtask

	task automatic pulseReset();
		@(posedge clk);
		#1 rst = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#1 rst = 1'b0;
	endtask

	task automatic runToHalt();
		pulseReset();
		while (halted !== 1'b1) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic arithmeticTest();
		logic [15:0] a;
		logic [15:0] b;
		logic [16:0] sum;
		logic [16:0] dbl;
		a = 16'd200;
		b = 16'd100;
		fillMemories();
		emitImmOp(cpuPkg::LDI, 1, a);
		emitImmOp(cpuPkg::LDI, 2, b);
		emitRegOp(cpuPkg::MOV, 3, 1);
		emitRegOp(cpuPkg::ADD, 3, 2);
		storeTo(8'h10, 3);
		storeCarryFlag(8'h11);
		emitRegOp(cpuPkg::MOV, 4, 1);
		emitRegOp(cpuPkg::SUB, 4, 2);
		storeTo(8'h12, 4);
		storeCarryFlag(8'h13);
		emitRegOp(cpuPkg::MOV, 5, 2);
		emitRegOp(cpuPkg::SUB, 5, 1);
		storeTo(8'h14, 5);
		storeCarryFlag(8'h15);
		// Doubling the wrapped difference carries out of bit 15
		emitRegOp(cpuPkg::MOV, 6, 5);
		emitRegOp(cpuPkg::ADD, 6, 5);
		storeTo(8'h16, 6);
		storeCarryFlag(8'h17);
		emitRegOp(cpuPkg::HALT, 0, 0);
		runToHalt();
		sum = a + b;
		dbl = {1'b0, b - a} + {1'b0, b - a};
		checkWord("arith", sum[15:0], dmem[8'h10]);
		checkWord("arith", {15'h0, sum[16]}, dmem[8'h11]);
		checkWord("arith", a - b, dmem[8'h12]);
		checkWord("arith", {15'h0, a < b}, dmem[8'h13]);
		checkWord("arith", b - a, dmem[8'h14]);
		checkWord("arith", {15'h0, b < a}, dmem[8'h15]);
		checkWord("arith", dbl[15:0], dmem[8'h16]);
		checkWord("arith", {15'h0, dbl[16]}, dmem[8'h17]);
	endtask

	task automatic logicTest();
		logic [15:0] a;
		logic [15:0] b;
		a = 16'h00c3;
		b = 16'h005a;
		fillMemories();
		emitImmOp(cpuPkg::LDI, 1, a);
		emitImmOp(cpuPkg::LDI, 2, b);
		emitRegOp(cpuPkg::MOV, 3, 1);
		emitRegOp(cpuPkg::AND, 3, 2);
		storeTo(8'h20, 3);
		emitRegOp(cpuPkg::MOV, 4, 1);
		emitRegOp(cpuPkg::OR, 4, 2);
		storeTo(8'h21, 4);
		emitRegOp(cpuPkg::MOV, 5, 1);
		emitRegOp(cpuPkg::XOR, 5, 2);
		storeTo(8'h22, 5);
		emitRegOp(cpuPkg::MOV, 6, 1);
		emitRegOp(cpuPkg::SHL, 6, 0);
		storeTo(8'h23, 6);
		emitRegOp(cpuPkg::MOV, 7, 1);
		emitRegOp(cpuPkg::SHR, 7, 0);
		storeTo(8'h24, 7);
		storeCarryFlag(8'h25);
		emitRegOp(cpuPkg::MOV, 8, 2);
		storeTo(8'h26, 8);
		emitRegOp(cpuPkg::HALT, 0, 0);
		runToHalt();
		checkWord("logic", a & b, dmem[8'h20]);
		checkWord("logic", a | b, dmem[8'h21]);
		checkWord("logic", a ^ b, dmem[8'h22]);
		checkWord("logic", a << 1, dmem[8'h23]);
		checkWord("logic", a >> 1, dmem[8'h24]);
		checkWord("logic", {15'h0, a[0]}, dmem[8'h25]);
		checkWord("logic", b, dmem[8'h26]);
	endtask

	task automatic loadStoreTest();
		fillMemories();
		dmemInit[8'h40] = 16'h1234;
		emitImmOp(cpuPkg::LDI, 1, 8'h40);
		emitRegOp(cpuPkg::LD, 2, 1);
		emitImmOp(cpuPkg::LDI, 3, 5);
		emitRegOp(cpuPkg::ADD, 2, 3);
		emitImmOp(cpuPkg::LDI, 4, 8'h50);
		emitRegOp(cpuPkg::ST, 4, 2);
		// Read back through the second pointer
		emitRegOp(cpuPkg::LD, 5, 4);
		storeTo(8'h51, 5);
		emitRegOp(cpuPkg::HALT, 0, 0);
		runToHalt();
		checkWord("loadstore", 16'h1234, dmem[8'h40]);
		checkWord("loadstore", 16'h1234 + 16'd5, dmem[8'h50]);
		checkWord("loadstore", 16'h1234 + 16'd5, dmem[8'h51]);
	endtask

	task automatic controlFlowTest();
		int loopTop;
		int count;
		count = 5;
		fillMemories();
		emitImmOp(cpuPkg::LDI, 1, count);
		emitImmOp(cpuPkg::LDI, 2, 1);
		emitImmOp(cpuPkg::LDI, 3, 0);
		loopTop = loadPtr;
		emitRegOp(cpuPkg::ADD, 3, 2);
		emitRegOp(cpuPkg::SUB, 1, 2);
		emitImmOp(cpuPkg::JZ, 0, loadPtr + 2);
		emitImmOp(cpuPkg::JMP, 0, loopTop);
		storeTo(8'h60, 3);
		emitImmOp(cpuPkg::JMP, 0, loadPtr + 3);
		storeTo(8'h61, 2);
		// JR target is one past the loaded value
		emitImmOp(cpuPkg::LDI, 4, loadPtr + 4);
		emitRegOp(cpuPkg::ADD, 4, 2);
		emitRegOp(cpuPkg::JR, 0, 4);
		storeTo(8'h62, 2);
		emitImmOp(cpuPkg::LDI, 5, 8'h77);
		storeTo(8'h63, 5);
		emitRegOp(cpuPkg::HALT, 0, 0);
		runToHalt();
		checkWord("control", 16'(count), dmem[8'h60]);
		checkWord("control", fillWord(8'h61), dmem[8'h61]);
		checkWord("control", fillWord(8'h62), dmem[8'h62]);
		checkWord("control", 16'h0077, dmem[8'h63]);
	endtask

	task automatic randomAluTest();
		logic [15:0] opA [4];
		logic [15:0] opB [4];
		for (int batch = 0; batch < 5; batch++) begin
			fillMemories();
			for (int k = 0; k < 4; k++) begin
				opA[k] = randWord();
				opB[k] = randWord();
				buildWord(1, opA[k]);
				buildWord(2, opB[k]);
				emitRegOp(cpuPkg::MOV, 3, 1);
				emitRegOp(cpuPkg::ADD, 3, 2);
				storeTo(8'h80 + 2 * k, 3);
				emitRegOp(cpuPkg::MOV, 4, 1);
				emitRegOp(cpuPkg::XOR, 4, 2);
				storeTo(8'h81 + 2 * k, 4);
			end
			emitRegOp(cpuPkg::HALT, 0, 0);
			runToHalt();
			for (int k = 0; k < 4; k++) begin
				checkWord("random", opA[k] + opB[k], dmem[8'h80 + 2 * k]);
				checkWord("random", opA[k] ^ opB[k], dmem[8'h81 + 2 * k]);
			end
		end
	endtask

	task automatic haltResetTest();
		int haltAddr;
		fillMemories();
		emitImmOp(cpuPkg::LDI, 1, 1);
		emitImmOp(cpuPkg::LDI, 2, 2);
		emitImmOp(cpuPkg::LDI, 3, 3);
		haltAddr = loadPtr;
		emitRegOp(cpuPkg::HALT, 0, 0);
		runToHalt();
		repeat (20) begin
			checkWord("halt", 16'(haltAddr + 1), instrAddr);
			checkWord("halt", 16'h1, {15'h0, halted});
			@(posedge clk);
			#1;
		end
		rst = 1'b1;
		#1;
		checkWord("reset", 16'h0, instrAddr);
		checkWord("reset", 16'h0, {15'h0, halted});
		repeat (resetCycles) @(posedge clk);
		#1 rst = 1'b0;
		// Two LDIs complete in four cycles
		repeat (4) @(posedge clk);
		#1;
		checkWord("reset", 16'h2, instrAddr);
		rst = 1'b1;
		#1;
		checkWord("reset", 16'h0, instrAddr);
		checkWord("reset", 16'h0, {15'h0, halted});
		repeat (resetCycles) @(posedge clk);
		#1 rst = 1'b0;
	endtask

	initial begin
		rst = 1'b1;
		arithmeticTest();
		logicTest();
		loadStoreTest();
		controlFlowTest();
		randomAluTest();
		haltResetTest();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
design/cpuPkg.sv
design/cpuCtrlIf.sv
design/instrDecoder.sv
design/registerFile.sv
design/alu.sv
design/programCounter.sv
design/controlSequencer.sv
design/cpuCore.sv
test/cpuCore_assertions.sv
test/cpuCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module cpuCoreTb -f src.f -o cpuCoreSim
./obj_dir/cpuCoreSim 2>&1 | tee sim.log || true

if grep -q "tests failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q "all tests passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation ok"
